/* common/vexec_pkg.sv */
//----------------------------
// shared types for the vector issue and scalar path
// opcode is the top byte of a word, then reg1, reg2, reg3
// opcodes not listed here execute as no-ops
//----------------------------
`default_nettype none

package vexec_pkg;

   localparam int WORD_W  = 32;
   localparam int FIELD_W = 8;
   localparam int VPTR_W  = 5;

   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [FIELD_W-1:0] reg_field_t;

   typedef enum logic [7:0] {
      NO_OP   = 8'd0,
      LV      = 8'd1,
      SV      = 8'd2,
      MTC1    = 8'd3,
      MFC1    = 8'd4,
      MOV_IMM = 8'd5
   } opcode_t;

   typedef enum logic {
      READ_REQ  = 1'b0,
      WRITE_REQ = 1'b1
   } access_t;

   // one decoded instruction, imm only meaningful for MOV_IMM
   typedef struct packed {
      logic       vld;
      opcode_t    op;
      reg_field_t reg1;
      reg_field_t reg2;
      reg_field_t reg3;
      word_t      imm;
   } dec_instr_t;

   typedef struct packed {
      logic              vld;
      access_t           access_type;
      word_t             access_length;
      logic [VPTR_W-1:0] vec_reg_ptr;
      word_t             addr;
   } ls_req_t;

   typedef struct packed {
      logic             en;
      logic [FIELD_W-1:0] addr;
      word_t            data;
   } sreg_wr_t;

endpackage

`default_nettype wire

/* design/instr_decode.sv */
//----------------------------
// alternating pop of the two buffers keeps program order
// a MOV_IMM header waits here for its data word
// dec_instr holds until exec_ready accepts it
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_decode
   import vexec_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  wire        empty0,
   input  wire        empty1,
   input  word_t      head0,
   input  word_t      head1,
   output logic       pop0,
   output logic       pop1,
   input  wire        exec_ready,
   output dec_instr_t dec_instr
);

   dec_instr_t dec_q;
   logic       last_grant;
   logic       hdr_pend;
   logic       can_take;
   logic       grant0;
   logic       grant1;
   logic       do_pop;
   word_t      sel_word;
   opcode_t    sel_op;

   // room when empty or leaving at this edge
   assign can_take = !dec_q.vld || exec_ready;

   // prefer the buffer not served last
   always_comb begin
      grant0 = 1'b0;
      grant1 = 1'b0;
      if (!empty0 && (last_grant || empty1)) begin
         grant0 = 1'b1;
      end else if (!empty1) begin
         grant1 = 1'b1;
      end
   end

   assign pop0     = can_take && grant0;
   assign pop1     = can_take && grant1;
   assign do_pop   = pop0 || pop1;
   assign sel_word = pop1 ? head1 : head0;
   assign sel_op   = opcode_t'(sel_word[31:24]);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         dec_q      <= '0;
         hdr_pend   <= 1'b0;
         // so the first grant goes to buffer 0
         last_grant <= 1'b1;
      end else begin
         if (do_pop) begin
            last_grant <= pop1;
            if (hdr_pend) begin
               // data word of a pending MOV_IMM
               dec_q.imm <= sel_word;
               dec_q.vld <= 1'b1;
               hdr_pend  <= 1'b0;
            end else begin
               dec_q.op   <= sel_op;
               dec_q.reg1 <= sel_word[23:16];
               dec_q.reg2 <= sel_word[15:8];
               dec_q.reg3 <= sel_word[7:0];
               dec_q.imm  <= '0;
               dec_q.vld  <= (sel_op != MOV_IMM);
               hdr_pend   <= (sel_op == MOV_IMM);
            end
         end else if (dec_q.vld && exec_ready) begin
            dec_q.vld <= 1'b0;
         end
      end
   end

   assign dec_instr = dec_q;

   a_one_pop: assert property (@(posedge clk) disable iff (!reset) !(pop0 && pop1))
      else $error("instr_decode popped both buffers");

endmodule

`default_nettype wire

/* design/scalar_reg_file.sv */
//----------------------------
// scalar registers, one read and one write port
// indices use the low log2(SCALAR_DEPTH) bits
// SCALAR_DEPTH up to 256, power of two
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module scalar_reg_file
   import vexec_pkg::*;
#(
   parameter int SCALAR_DEPTH = 16
) (
   input  wire        clk,
   input  wire        reset,
   input  reg_field_t rd_addr,
   output word_t      rd_data,
   input  sreg_wr_t   wr
);

   localparam int IDX_W = $clog2(SCALAR_DEPTH);

   word_t regs [SCALAR_DEPTH];

   // same-cycle read, new data visible after the write edge
   assign rd_data = regs[rd_addr[IDX_W-1:0]];

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < SCALAR_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en) begin
         regs[wr.addr[IDX_W-1:0]] <= wr.data;
      end
   end

endmodule

`default_nettype wire

/* design/vector_exec.sv */
//----------------------------
// scalar execute and load/store issue
// one LV or SV outstanding, held until busy drops
// scalar reads are combinational from the register file
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module vector_exec
   import vexec_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  dec_instr_t dec_instr,
   output logic       exec_ready,
   output reg_field_t sreg_rd_addr,
   input  word_t      sreg_rd_data,
   output sreg_wr_t   sreg_wr,
   output ls_req_t    load_store_req,
   input  wire        load_store_busy
);

   ls_req_t ls_q;
   word_t   vec_len;
   logic    accept;

   assign exec_ready = !ls_q.vld;
   assign accept     = dec_instr.vld && exec_ready;

   // read index for address and length sources
   always_comb begin
      case (dec_instr.op)
         LV, SV, MTC1: sreg_rd_addr = dec_instr.reg2;
         default:      sreg_rd_addr = '0;
      endcase
   end

   // MFC1 and MOV_IMM write back at the accept edge
   always_comb begin
      sreg_wr.en   = accept && ((dec_instr.op == MFC1) || (dec_instr.op == MOV_IMM));
      sreg_wr.addr = dec_instr.reg1;
      sreg_wr.data = (dec_instr.op == MFC1) ? vec_len : dec_instr.imm;
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         ls_q    <= '0;
         vec_len <= '0;
      end else if (ls_q.vld) begin
         // retire once the load/store unit is free
         if (!load_store_busy) begin
            ls_q <= '0;
         end
      end else if (accept) begin
         case (dec_instr.op)
            LV, SV: begin
               ls_q.vld           <= 1'b1;
               ls_q.access_type   <= (dec_instr.op == LV) ? READ_REQ : WRITE_REQ;
               ls_q.access_length <= vec_len;
               ls_q.vec_reg_ptr   <= dec_instr.reg1[VPTR_W-1:0];
               ls_q.addr          <= sreg_rd_data;
            end
            MTC1: begin
               vec_len <= sreg_rd_data;
            end
            default: begin
               // MFC1 and MOV_IMM only write scalars, others are no-ops
            end
         endcase
      end
   end

   assign load_store_req = ls_q;

   a_req_stable: assert property (@(posedge clk) disable iff (!reset)
      (load_store_req.vld && load_store_busy) |=> $stable(load_store_req))
      else $error("load/store request changed while busy");

endmodule

`default_nettype wire

/* design/vexec_unit.sv */
//----------------------------
// vector issue and scalar execute top level
// opcode_vld must stay low while inst_buff_full is high
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module vexec_unit
   import vexec_pkg::*;
#(
   parameter int BUF_DEPTH    = 4,
   parameter int SCALAR_DEPTH = 16
) (
   input  wire     clk,
   input  wire     reset,
   input  wire     opcode_vld,
   input  word_t   opcode0,
   input  word_t   opcode1,
   output logic    inst_buff_full,
   output ls_req_t load_store_req,
   input  wire     load_store_busy
);

   logic       full0;
   logic       full1;
   logic       empty0;
   logic       empty1;
   logic       pop0;
   logic       pop1;
   word_t      head0;
   word_t      head1;
   dec_instr_t dec_instr;
   logic       exec_ready;
   reg_field_t sreg_rd_addr;
   word_t      sreg_rd_data;
   sreg_wr_t   sreg_wr;

   assign inst_buff_full = full0 || full1;

   // both channels of a pair are written together
   instr_buffer #(.BUF_DEPTH(BUF_DEPTH)) buffer0 (
      .clk     (clk),
      .reset   (reset),
      .wr      (opcode_vld),
      .wr_data (opcode0),
      .full    (full0),
      .pop     (pop0),
      .empty   (empty0),
      .head    (head0)
   );

   instr_buffer #(.BUF_DEPTH(BUF_DEPTH)) buffer1 (
      .clk     (clk),
      .reset   (reset),
      .wr      (opcode_vld),
      .wr_data (opcode1),
      .full    (full1),
      .pop     (pop1),
      .empty   (empty1),
      .head    (head1)
   );

   instr_decode u_decode (
      .clk        (clk),
      .reset      (reset),
      .empty0     (empty0),
      .empty1     (empty1),
      .head0      (head0),
      .head1      (head1),
      .pop0       (pop0),
      .pop1       (pop1),
      .exec_ready (exec_ready),
      .dec_instr  (dec_instr)
   );

   vector_exec u_exec (
      .clk             (clk),
      .reset           (reset),
      .dec_instr       (dec_instr),
      .exec_ready      (exec_ready),
      .sreg_rd_addr    (sreg_rd_addr),
      .sreg_rd_data    (sreg_rd_data),
      .sreg_wr         (sreg_wr),
      .load_store_req  (load_store_req),
      .load_store_busy (load_store_busy)
   );

   scalar_reg_file #(.SCALAR_DEPTH(SCALAR_DEPTH)) u_sregs (
      .clk     (clk),
      .reset   (reset),
      .rd_addr (sreg_rd_addr),
      .rd_data (sreg_rd_data),
      .wr      (sreg_wr)
   );

endmodule

`default_nettype wire

/* instr_buffer/instr_buffer.sv */
//----------------------------
// instruction FIFO for one fetch channel
// BUF_DEPTH must be a power of two, 2 or more
// writes while full are dropped and flagged
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_buffer
   import vexec_pkg::*;
#(
   parameter int BUF_DEPTH = 4
) (
   input  wire   clk,
   input  wire   reset,
   input  wire   wr,
   input  word_t wr_data,
   output logic  full,
   input  wire   pop,
   output logic  empty,
   output word_t head
);

   localparam int PTR_W = $clog2(BUF_DEPTH);

   word_t            mem [BUF_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_wr;
   logic             do_pop;

   assign full   = (count == BUF_DEPTH[PTR_W:0]);
   assign empty  = (count == '0);
   assign head   = mem[rd_ptr];
   assign do_wr  = wr && !full;
   assign do_pop = pop && !empty;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage, pointers wrap naturally
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // fetch source must hold off while full
   a_no_wr_full: assert property (@(posedge clk) disable iff (!reset) !(wr && full))
      else $error("instr_buffer write while full");

   // decode only pops a buffer it sees as non-empty
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset) !(pop && empty))
      else $error("instr_buffer pop while empty");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the vexec testbench with Verilator
# a failing run is one whose log holds the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vexec_tb -o vexec_sim -f src.f \
   || { echo "verilator build failed"; exit 1; }
./obj_dir/vexec_sim > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

/* src.f */
common/vexec_pkg.sv
instr_buffer/instr_buffer.sv
design/instr_decode.sv
design/vector_exec.sv
design/scalar_reg_file.sv
design/vexec_unit.sv
verification/vexec_tb.sv

/* verification/vexec_tb.sv */
//------------------------------
// testbench for vexec_unit
// all programs are modeled before the run, requests checked in order
// register fields carry random upper bits to exercise index masking
// fetch writes at most one pair every other cycle
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module vexec_tb
   import vexec_pkg::*;
();

   localparam int BUF_DEPTH    = 4;
   localparam int SCALAR_DEPTH = 16;

   logic    clk;
   logic    reset;
   logic    opcode_vld;
   word_t   opcode0;
   word_t   opcode1;
   logic    inst_buff_full;
   ls_req_t load_store_req;
   logic    load_store_busy;

   word_t   prog[$];
   ls_req_t exp_q[$];
   int      busy_len[$];
   word_t   model_sregs [SCALAR_DEPTH];
   word_t   model_vlen;
   ls_req_t exp_head;
   int      exp_left;
   int      bp_start;
   int      busy_total;
   int      watch_limit;
   logic    bp_phase   = 1'b0;
   logic    full_seen  = 1'b0;
   logic    in_reset_q = 1'b0;
   logic    req_vld_q  = 1'b0;

   vexec_unit #(
      .BUF_DEPTH    (BUF_DEPTH),
      .SCALAR_DEPTH (SCALAR_DEPTH)
   ) dut (
      .clk             (clk),
      .reset           (reset),
      .opcode_vld      (opcode_vld),
      .opcode0         (opcode0),
      .opcode1         (opcode1),
      .inst_buff_full  (inst_buff_full),
      .load_store_req  (load_store_req),
      .load_store_busy (load_store_busy)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   function automatic logic [7:0] rand_field();
      return 8'($urandom);
   endfunction

   // reg3 is unused by every kept opcode, so it gets junk
   function automatic word_t make_word(input logic [7:0] op, input logic [7:0] r1,
                                       input logic [7:0] r2);
      return {op, r1, r2, rand_field()};
   endfunction

   task automatic add_word(input word_t w);
      prog.push_back(w);
   endtask

   // NO_OP or an undefined opcode
   task automatic add_junk();
      logic [7:0] op;
      op = ($urandom_range(0, 1) == 0) ? 8'd0 : 8'($urandom_range(6, 255));
      add_word(make_word(op, rand_field(), rand_field()));
   endtask

   task automatic build_programs();
      logic [7:0] k;
      // immediate used as an LV address
      k = rand_field();
      add_word(make_word(MOV_IMM, k, rand_field()));
      add_word($urandom);
      add_word(make_word(LV, rand_field(), k));
      add_junk();
      // immediate used as a vector length for SV
      k = rand_field();
      add_word(make_word(MOV_IMM, k, rand_field()));
      add_word($urandom);
      add_word(make_word(MTC1, rand_field(), k));
      add_word(make_word(SV, rand_field(), rand_field()));
      // same, header on channel 1 and data on channel 0 of the next pair
      add_junk();
      k = rand_field();
      add_word(make_word(MOV_IMM, k, rand_field()));
      add_word($urandom);
      add_word(make_word(MTC1, rand_field(), k));
      add_word(make_word(SV, rand_field(), rand_field()));
      add_junk();
      // length read back with MFC1 and used as an address
      k = rand_field();
      add_word(make_word(MOV_IMM, k, rand_field()));
      add_word($urandom);
      add_word(make_word(MTC1, rand_field(), k));
      add_junk();
      k = rand_field();
      add_word(make_word(MFC1, k, rand_field()));
      add_word(make_word(LV, rand_field(), k));
      // back-pressure section, ends on an LV/SV pair
      bp_start = prog.size();
      for (int n = 0; n < 20; n++) begin
         if (n % 4 == 0) begin
            k = rand_field();
            add_word(make_word(MOV_IMM, k, rand_field()));
            add_word($urandom);
            add_word(make_word(MTC1, rand_field(), k));
            add_junk();
         end
         add_word(make_word(LV, rand_field(), rand_field()));
         add_word(make_word(SV, rand_field(), rand_field()));
         repeat (2) begin
            busy_len.push_back($urandom_range(0, 5));
            busy_total += busy_len[busy_len.size() - 1];
         end
      end
   endtask

   // program order model of the scalar state and request stream
   task automatic run_model();
      int         i;
      int         r1;
      int         r2;
      word_t      w;
      logic [7:0] op;
      ls_req_t    req;
      i = 0;
      while (i < prog.size()) begin
         w  = prog[i];
         op = w[31:24];
         r1 = int'(w[23:16]) % SCALAR_DEPTH;
         r2 = int'(w[15:8]) % SCALAR_DEPTH;
         i++;
         case (op)
            LV, SV: begin
               req.vld           = 1'b1;
               req.access_type   = (op == LV) ? READ_REQ : WRITE_REQ;
               req.access_length = model_vlen;
               req.vec_reg_ptr   = w[20:16];
               req.addr          = model_sregs[r2];
               exp_q.push_back(req);
            end
            MTC1: model_vlen = model_sregs[r2];
            MFC1: model_sregs[r1] = model_vlen;
            MOV_IMM: begin
               model_sregs[r1] = prog[i];
               i++;
            end
            default: begin
            end
         endcase
      end
   endtask

   // previous cycle had no write, so full cannot rise under this write
   task automatic send_pair(input word_t w0, input word_t w1);
      @(posedge clk);
      while (inst_buff_full) begin
         @(posedge clk);
      end
      opcode_vld <= 1'b1;
      opcode0    <= w0;
      opcode1    <= w1;
      @(posedge clk);
      opcode_vld <= 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // expected head advances when a request appears
   always @(posedge clk) begin
      req_vld_q  <= load_store_req.vld;
      in_reset_q <= !reset;
      if (inst_buff_full) begin
         full_seen <= 1'b1;
      end
      if (reset && load_store_req.vld && !req_vld_q && exp_q.size() > 0) begin
         void'(exp_q.pop_front());
         exp_left <= exp_q.size();
         exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
      end
   end

   a_reset_quiet: assert property (@(posedge clk)
      in_reset_q |-> (!load_store_req.vld && !inst_buff_full))
      else abort_run($sformatf("Error at %0t: outputs active in or right after reset", $time));

   a_req_order: assert property (@(posedge clk) disable iff (!reset)
      $rose(load_store_req.vld) |-> (exp_left > 0 && load_store_req == exp_head))
      else abort_run($sformatf("Error at %0t: request %h, expected %h with %0d left", $time,
                               $sampled(load_store_req), $sampled(exp_head), $sampled(exp_left)));

   a_req_hold: assert property (@(posedge clk) disable iff (!reset)
      (load_store_req.vld && load_store_busy) |=> $stable(load_store_req))
      else abort_run($sformatf("Error at %0t: request fields changed while busy", $time));

   // busy stretches only during the back-pressure section
   initial begin
      wait (bp_phase);
      foreach (busy_len[n]) begin
         repeat (busy_len[n]) begin
            @(posedge clk);
            load_store_busy <= 1'b1;
         end
         @(posedge clk);
         load_store_busy <= 1'b0;
      end
   end

   initial begin
      wait (reset);
      repeat (watch_limit) @(posedge clk);
      abort_run("simulation timed out before all load/store requests retired");
   end

   initial begin
      reset           = 1'b0;
      opcode_vld      = 1'b0;
      opcode0         = '0;
      opcode1         = '0;
      load_store_busy = 1'b0;
      busy_total      = 0;
      model_vlen      = '0;
      foreach (model_sregs[i]) begin
         model_sregs[i] = '0;
      end
      void'($urandom(79));
      build_programs();
      run_model();
      exp_left    = exp_q.size();
      exp_head    = exp_q[0];
      watch_limit = prog.size() * 20 + busy_total + 100;

      repeat (10) @(posedge clk);
      reset <= 1'b1;

      for (int i = 0; i < prog.size(); i += 2) begin
         if (i == bp_start) begin
            bp_phase = 1'b1;
         end
         send_pair(prog[i], prog[i + 1]);
      end

      // last word is an SV, so the run is done once it retires
      while (exp_left != 0 || load_store_req.vld) begin
         @(posedge clk);
      end

      if (exp_q.size() != 0) begin
         abort_run("expected load/store requests were never issued");
      end else if (!full_seen) begin
         abort_run("inst_buff_full never went high under back-pressure");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
